/* hdl/audio_mixer.sv */
`default_nettype none

module audio_mixer import ste_audio_pkg::*; (
	input  wire             clk_32,
	input  wire             xsint,
	input  wire psg_sum_t   psg_l_i,
	input  wire psg_sum_t   psg_r_i,
	input  wire [DMA_W-1:0] dma_l_i,
	input  wire [DMA_W-1:0] dma_r_i,
	output mix_t            mix_l_o,
	output mix_t            mix_r_o
);

	// psg sum to signed 14 bit, sign copied once more on top
	// e.g. 0x3ff centers to 0x1ff with fill 0x7 for near full scale
	function automatic mix_t widen_psg(input psg_sum_t sum);
		logic [PSG_SUM_W-1:0] s;
		s = sum - PSG_SUM_W'(PSG_MID);
		return {s[PSG_SUM_W-1], s, s[PSG_SUM_W-1 -: PSG_FILL_W]};
	endfunction

	// same idea for the dma byte with a wider fill
	function automatic mix_t widen_dma(input logic [DMA_W-1:0] sample);
		logic [DMA_W-1:0] d;
		d = sample - DMA_W'(DMA_MID);
		return {d[DMA_W-1], d, d[DMA_W-1 -: DMA_FILL_W]};
	endfunction

	mix_t psg_l_w;
	mix_t psg_r_w;
	mix_t dma_l_w;
	mix_t dma_r_w;

	mix_t mix_l_nxt;
	mix_t mix_r_nxt;

	assign psg_l_w = widen_psg(psg_l_i);
	assign psg_r_w = widen_psg(psg_r_i);

	// dma samples come straight from the top level ports
	assign dma_l_w = widen_dma(dma_l_i);
	assign dma_r_w = widen_dma(dma_r_i);

	// two 14 bit values, sum wraps at 15 bits
	assign mix_l_nxt = psg_l_w + dma_l_w;
	assign mix_r_nxt = psg_r_w + dma_r_w;

	// second pipeline stage
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= mix_l_nxt;
			mix_r_o <= mix_r_nxt;
		end
	end

endmodule

`default_nettype wire

/* hdl/psg_channel_mix.sv */
`default_nettype none

module psg_channel_mix import ste_audio_pkg::*; (
	input  wire                clk_32,
	input  wire                xsint,
	input  wire [PSG_CH_W-1:0] ym_a_i,
	input  wire [PSG_CH_W-1:0] ym_b_i,
	input  wire [PSG_CH_W-1:0] ym_c_i,
	input  wire                psg_stereo_i,
	output psg_sum_t           psg_l_o,
	output psg_sum_t           psg_r_o
);

	psg_mode_e mode;

	// channels zero extended to the sum width
	psg_sum_t ch_a;
	psg_sum_t ch_b;
	psg_sum_t ch_c;

	psg_sum_t sum_ab;
	psg_sum_t sum_cb;
	psg_sum_t sum_abc;

	// routed sums, registered below
	psg_sum_t sum_l;
	psg_sum_t sum_r;

	assign mode = psg_mode_e'(psg_stereo_i);

	assign ch_a = PSG_SUM_W'(ym_a_i);
	assign ch_b = PSG_SUM_W'(ym_b_i);
	assign ch_c = PSG_SUM_W'(ym_c_i);

	// no overflow possible with two spare bits
	assign sum_ab  = ch_a + ch_b;
	assign sum_cb  = ch_c + ch_b;
	assign sum_abc = sum_ab + ch_c;

	always_comb begin
		case (mode)
			PSG_STEREO: begin
				sum_l = sum_ab;    // b is heard on both sides
				sum_r = sum_cb;
			end
			default: begin
				sum_l = sum_abc;   // mono, all three everywhere
				sum_r = sum_abc;
			end
		endcase
	end

	// first pipeline stage
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			psg_l_o <= '0;
			psg_r_o <= '0;
		end else begin
			psg_l_o <= sum_l;
			psg_r_o <= sum_r;
		end
	end

endmodule

`default_nettype wire

/* hdl/sigma_delta_channel.sv */
`default_nettype none

module sigma_delta_channel import ste_audio_pkg::*; (
	input  wire       clk_32,
	input  wire       xsint,
	input  wire mix_t mix_i,
	output wire       bit_o
);

	// offset binary version of the mix, 0 = most negative
	logic [MIX_W-1:0] offs;

	// accumulator keeps only the bits below the carry
	logic [DAC_ACC_W-2:0] acc_q;
	logic [DAC_ACC_W-1:0] acc_sum;
	logic                 carry_q;

	assign offs = {~mix_i[MIX_W-1], mix_i[MIX_W-2:0]};

	// first order loop, old remainder plus new sample
	assign acc_sum = {1'b0, acc_q} + {1'b0, offs};

	// third pipeline stage
	// carry density follows offs / 2^15
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_q   <= '0;
			carry_q <= 1'b0;
		end else begin
			acc_q   <= acc_sum[DAC_ACC_W-2:0];   // carry dropped
			carry_q <= acc_sum[DAC_ACC_W-1];
		end
	end

	assign bit_o = carry_q;   // straight to the pin

endmodule

`default_nettype wire

/* hdl/ste_audio_pkg.sv */
`default_nettype none

package ste_audio_pkg;

	// ym2149 tone channels
	localparam int unsigned PSG_CH_W  = 8;     // one unsigned channel level
	localparam int unsigned PSG_SUM_W = 10;    // a+b+c tops out at 765
	localparam int unsigned PSG_MID   = 512;   // center of the 10 bit sum

	// ste dma sound, one unsigned byte per side
	localparam int unsigned DMA_W   = 8;
	localparam int unsigned DMA_MID = 128;

	// signed mix per side and the dac accumulator behind it
	localparam int unsigned MIX_W     = 15;
	localparam int unsigned DAC_ACC_W = 16;    // carry out is the dac bit

	// both sources widen to 14 bits plus a sign copy in the mix
	// the low bits are filled from the source's own top bits
	localparam int unsigned PSG_FILL_W = MIX_W - 1 - PSG_SUM_W;   // 4
	localparam int unsigned DMA_FILL_W = MIX_W - 1 - DMA_W;       // 6

	typedef logic [PSG_SUM_W-1:0] psg_sum_t;      // unsigned tone sum
	typedef logic signed [MIX_W-1:0] mix_t;      // centered audio mix

	// psg channel routing
	typedef enum logic {
		PSG_MONO   = 1'b0,   // a+b+c on both sides
		PSG_STEREO = 1'b1    // a+b left, c+b right
	} psg_mode_e;

endpackage

`default_nettype wire

/* hdl/ste_audio_top.sv */
`default_nettype none

module ste_audio_top import ste_audio_pkg::*; (
	input  wire                clk_32,
	input  wire                xsint,
	input  wire [PSG_CH_W-1:0] ym_a_i,
	input  wire [PSG_CH_W-1:0] ym_b_i,
	input  wire [PSG_CH_W-1:0] ym_c_i,
	input  wire [DMA_W-1:0]    dma_l_i,
	input  wire [DMA_W-1:0]    dma_r_i,
	input  wire                psg_stereo_i,
	output wire                audio_l_o,
	output wire                audio_r_o
);

	// tone sums after stage one
	psg_sum_t psg_l;
	psg_sum_t psg_r;

	// signed mixes after stage two
	mix_t mix_l;
	mix_t mix_r;

	psg_channel_mix psg_channel_mix_i (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.ym_a_i       ( ym_a_i       ),
		.ym_b_i       ( ym_b_i       ),
		.ym_c_i       ( ym_c_i       ),
		.psg_stereo_i ( psg_stereo_i ),
		.psg_l_o      ( psg_l        ),
		.psg_r_o      ( psg_r        )
	);

	audio_mixer audio_mixer_i (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.psg_l_i      ( psg_l        ),
		.psg_r_i      ( psg_r        ),
		.dma_l_i      ( dma_l_i      ),   // dma bypasses stage one
		.dma_r_i      ( dma_r_i      ),
		.mix_l_o      ( mix_l        ),
		.mix_r_o      ( mix_r        )
	);

	// one modulator per audio pin
	sigma_delta_channel sigma_delta_l_i (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.mix_i        ( mix_l        ),
		.bit_o        ( audio_l_o    )
	);

	sigma_delta_channel sigma_delta_r_i (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.mix_i        ( mix_r        ),
		.bit_o        ( audio_r_o    )
	);

endmodule

`default_nettype wire

/* ste_audio_top.f */
hdl/ste_audio_pkg.sv
hdl/psg_channel_mix.sv
hdl/audio_mixer.sv
hdl/sigma_delta_channel.sv
hdl/ste_audio_top.sv
test/ste_audio_chk.sv
test/ste_audio_tb.sv

/* test/ste_audio_chk.sv */
`default_nettype none

module ste_audio_chk import ste_audio_pkg::*; (
	input wire                 clk_32,
	input wire                 xsint,
	input wire                 psg_stereo_i,
	input wire [DMA_W-1:0]     dma_l_i,
	input wire [DMA_W-1:0]     dma_r_i,
	input wire                 audio_l_i,
	input wire                 audio_r_i,
	input wire [DAC_ACC_W-2:0] acc_l_i,   // modulator remainders
	input wire [DAC_ACC_W-2:0] acc_r_i
);

	int fails;   // assertion failures so far

	// both sides see the same sources
	sequence mono_equal_s;
		!psg_stereo_i && (dma_l_i == dma_r_i);
	endsequence

	// async reset holds the pins low
	reset_low_a: assert property (@(posedge clk_32)
		!xsint |-> (!audio_l_i && !audio_r_i))
		else begin
			fails++;
			$error("audio pin high while xsint is low");
		end

	// equal mixes give equal bits only from equal remainders
	mono_match_a: assert property (@(posedge clk_32) disable iff (!xsint)
		(mono_equal_s [*3] ##0 (acc_l_i == acc_r_i)) |=> (audio_l_i == audio_r_i))
		else begin
			fails++;
			$error("left and right bitstreams differ in mono mode");
		end

	known_a: assert property (@(posedge clk_32) disable iff (!xsint)
		!$isunknown({audio_l_i, audio_r_i}))
		else begin
			fails++;
			$error("audio pin unknown after reset release");
		end

endmodule

`default_nettype wire

/* test/ste_audio_tb.sv */
`default_nettype none

module ste_audio_tb import ste_audio_pkg::*; ();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int EDGE_TIMEOUT = 4 * CLK_PERIOD;

	// stimulus flavours
	localparam int MODE_MONO     = 0;   // dma left equals right
	localparam int MODE_STEREO   = 1;
	localparam int MODE_DMA_ONLY = 2;
	localparam int MODE_TOGGLE   = 3;

	logic                clk_32;
	logic                xsint;
	logic [PSG_CH_W-1:0] ym_a;
	logic [PSG_CH_W-1:0] ym_b;
	logic [PSG_CH_W-1:0] ym_c;
	logic [DMA_W-1:0]    dma_l;
	logic [DMA_W-1:0]    dma_r;
	logic                psg_stereo;
	wire                 audio_l;
	wire                 audio_r;

	// reference model state, one set per pipeline stage
	logic [PSG_SUM_W-1:0] m_psg_l;
	logic [PSG_SUM_W-1:0] m_psg_r;
	logic [MIX_W-1:0]     m_mix_l;
	logic [MIX_W-1:0]     m_mix_r;
	logic [MIX_W-1:0]     m_acc_l;
	logic [MIX_W-1:0]     m_acc_r;
	logic                 m_bit_l;
	logic                 m_bit_r;

	logic [31:0] rng;
	logic        mono_cmp;
	int          checks;
	int          errors;
	int          check_mark;
	int          error_mark;
	int          chk_mark;

	ste_audio_top ste_audio_top_i (
		.clk_32       ( clk_32     ),
		.xsint        ( xsint      ),
		.ym_a_i       ( ym_a       ),
		.ym_b_i       ( ym_b       ),
		.ym_c_i       ( ym_c       ),
		.dma_l_i      ( dma_l      ),
		.dma_r_i      ( dma_r      ),
		.psg_stereo_i ( psg_stereo ),
		.audio_l_o    ( audio_l    ),
		.audio_r_o    ( audio_r    )
	);

	bind ste_audio_top ste_audio_chk ste_audio_chk_i (
		.clk_32       ( clk_32                ),
		.xsint        ( xsint                 ),
		.psg_stereo_i ( psg_stereo_i          ),
		.dma_l_i      ( dma_l_i               ),
		.dma_r_i      ( dma_r_i               ),
		.audio_l_i    ( audio_l_o             ),
		.audio_r_i    ( audio_r_o             ),
		.acc_l_i      ( sigma_delta_l_i.acc_q ),
		.acc_r_i      ( sigma_delta_r_i.acc_q )
	);

	always #(CLK_PERIOD / 2) clk_32 = ~clk_32;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// b is shared by both sides in stereo
	function automatic int tone_sum(input int a, input int b, input int c,
			input logic stereo, input logic right);
		if (!stereo)
			return a + b + c;
		return right ? c + b : a + b;
	endfunction

	// centered sum times 16, low nibble from its own top bits
	function automatic int psg_to_mix(input int sum);
		int s;
		s = sum - int'(PSG_MID);
		return s * 16 + int'((s & 'h3ff) >> 6);
	endfunction

	function automatic int dma_to_mix(input int sample);
		int d;
		d = sample - int'(DMA_MID);
		return d * 64 + int'((d & 'hff) >> 2);   // six fill bits
	endfunction

	// 15 bit pattern with the sign flipped, 0 is full negative
	function automatic int mix_offs(input int mix);
		return (mix & 'h7fff) ^ 'h4000;
	endfunction

	always @(posedge clk_32 or negedge xsint) begin : model
		int next_l;
		int next_r;
		if (!xsint) begin
			m_psg_l <= '0;
			m_psg_r <= '0;
			m_mix_l <= '0;
			m_mix_r <= '0;
			m_acc_l <= '0;
			m_acc_r <= '0;
			m_bit_l <= 1'b0;
			m_bit_r <= 1'b0;
		end else begin
			m_psg_l <= PSG_SUM_W'(tone_sum(ym_a, ym_b, ym_c, psg_stereo, 1'b0));
			m_psg_r <= PSG_SUM_W'(tone_sum(ym_a, ym_b, ym_c, psg_stereo, 1'b1));
			// dma enters at the mixer stage
			m_mix_l <= MIX_W'(psg_to_mix(m_psg_l) + dma_to_mix(dma_l));
			m_mix_r <= MIX_W'(psg_to_mix(m_psg_r) + dma_to_mix(dma_r));
			next_l = int'(m_acc_l) + mix_offs(m_mix_l);
			next_r = int'(m_acc_r) + mix_offs(m_mix_r);
			m_acc_l <= MIX_W'(next_l);
			m_acc_r <= MIX_W'(next_r);
			m_bit_l <= (next_l >= 32768);   // carry out
			m_bit_r <= (next_r >= 32768);
		end
	end

	// outputs are settled mid cycle
	always @(negedge clk_32) begin
		checks += 2;
		assert (audio_l === m_bit_l) else begin
			errors++;
			$display("CHECK FAILED audio_l_o: expected %h, got %h at %0t",
				m_bit_l, audio_l, $time);
		end
		assert (audio_r === m_bit_r) else begin
			errors++;
			$display("CHECK FAILED audio_r_o: expected %h, got %h at %0t",
				m_bit_r, audio_r, $time);
		end
		if (mono_cmp) begin
			checks++;
			assert (audio_l === audio_r) else begin
				errors++;
				$display("CHECK FAILED audio_r_o: expected %h (left), got %h at %0t",
					audio_l, audio_r, $time);
			end
		end
	end

	task automatic next_edge();
		fork
			@(posedge clk_32);
			begin
				#(EDGE_TIMEOUT);
				$display("timeout, clk_32 stopped toggling at %0t", $time);
				$display("Some tests failed");
				$finish;
			end
		join_any
		disable fork;
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			next_edge();
	endtask

	task automatic random_inputs(input int mode);
		logic [31:0] r;
		logic [31:0] s;
		rng = xorshift32(rng);
		r = rng;
		rng = xorshift32(rng);
		s = rng;
		if (mode == MODE_DMA_ONLY) begin
			ym_a <= 8'hab;   // 0xab + 0xaa + 0xab = 512
			ym_b <= 8'haa;
			ym_c <= 8'hab;
		end else begin
			ym_a <= r[7:0];
			ym_b <= r[15:8];
			ym_c <= r[23:16];
		end
		dma_l <= r[31:24];
		dma_r <= (mode == MODE_MONO) ? r[31:24] : s[7:0];
		psg_stereo <= (mode == MODE_STEREO) || (mode == MODE_TOGGLE && s[8]);
	endtask

	task automatic random_run(input int n, input int mode);
		for (int i = 0; i < n; i++) begin
			next_edge();
			random_inputs(mode);
		end
	endtask

	// sampled right after the edge, before the registers move
	task automatic expect_low();
		checks += 2;
		assert (audio_l === 1'b0 && audio_r === 1'b0) else begin
			errors++;
			$display("CHECK FAILED audio_l_o/audio_r_o: expected 0/0, got %h/%h", audio_l,
				audio_r);
		end
	endtask

	// ones over 1024 cycles should be offs / 32, give or take one
	task automatic check_density(input string name, input int ones, input int offs);
		checks++;
		assert (ones * 32 >= offs - 32 && ones * 32 <= offs + 32) else begin
			errors++;
			$display("CHECK FAILED %s ones: expected %h, got %h", name, offs / 32, ones);
		end
	endtask

	task automatic density_run();
		int ones_l;
		int ones_r;
		int offs_l;
		int offs_r;
		next_edge();
		random_inputs(MODE_TOGGLE);
		wait_cycles(4);   // let the held sample reach the pins
		offs_l = mix_offs(psg_to_mix(tone_sum(ym_a, ym_b, ym_c, psg_stereo, 1'b0))
			+ dma_to_mix(dma_l));
		offs_r = mix_offs(psg_to_mix(tone_sum(ym_a, ym_b, ym_c, psg_stereo, 1'b1))
			+ dma_to_mix(dma_r));
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < 1024; i++) begin
			next_edge();
			ones_l += audio_l;
			ones_r += audio_r;
		end
		check_density("audio_l_o", ones_l, offs_l);
		check_density("audio_r_o", ones_r, offs_r);
	endtask

	// bound assertion failures count as errors of the test that saw them
	task automatic end_test(input string name);
		int chk_fails;
		chk_fails = ste_audio_top_i.ste_audio_chk_i.fails;
		errors += chk_fails - chk_mark;
		chk_mark = chk_fails;
		$display("%s: %0d checks, %0d errors", name, checks - check_mark,
			errors - error_mark);
		check_mark = checks;
		error_mark = errors;
	endtask

	initial begin
		clk_32     = 1'b0;
		xsint      = 1'b1;
		ym_a       = '0;
		ym_b       = '0;
		ym_c       = '0;
		dma_l      = '0;
		dma_r      = '0;
		psg_stereo = 1'b0;
		rng        = 32'h830d1c94;
		mono_cmp   = 1'b0;
		checks     = 0;
		errors     = 0;
		check_mark = 0;
		error_mark = 0;
		chk_mark   = 0;
		#1 xsint = 1'b0;   // falling edge fires the async reset

		for (int i = 0; i < RESET_CYCLES; i++) begin
			next_edge();
			if (i > 0)
				expect_low();
		end
		xsint <= 1'b1;
		next_edge();
		expect_low();
		next_edge();
		expect_low();
		end_test("reset state");

		mono_cmp = 1'b1;
		random_run(500, MODE_MONO);
		mono_cmp = 1'b0;
		end_test("mono mode");

		random_run(500, MODE_STEREO);
		end_test("stereo split");

		random_run(500, MODE_DMA_ONLY);
		end_test("dma only");

		for (int k = 0; k < 4; k++)
			density_run();
		end_test("density");

		random_run(2000, MODE_TOGGLE);
		end_test("mode switching");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
